// File: rtl/uart_pkg.sv
package uart_pkg;

	// One received data byte.
	typedef logic [7:0] uart_byte_t;

	// Register addresses seen by the host.
	typedef logic [1:0] uart_addr_t;

	localparam uart_addr_t addr_data = 2'd0;
	localparam uart_addr_t addr_status = 2'd1;
	localparam uart_addr_t addr_reserved_2 = 2'd2;
	localparam uart_addr_t addr_reserved_3 = 2'd3;

	// Status flags from overrun in bit 0 up to full in bit 3.
	typedef struct packed {
		logic full;
		logic frame_error;
		logic empty;
		logic overrun;
	} uart_status_t;

	// Data register layout.
	typedef struct packed {
		logic [23:0] zero;
		uart_byte_t value;
	} uart_data_view_t;

	// Status register layout.
	typedef struct packed {
		logic [27:0] zero;
		uart_status_t flags;
	} uart_status_view_t;

	// One read word, decoded by the address of the read.
	typedef union packed {
		uart_data_view_t data;
		uart_status_view_t status;
	} uart_rdata_u;

endpackage

// File: rtl/uart_rx_sampler.sv
`timescale 1ns/1ps

module uart_rx_sampler import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_rx,
	output uart_byte_t o_byte,
	output logic o_byte_valid,
	output logic o_frame_error
);

	localparam int COUNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [COUNT_W-1:0] FULL_BIT = COUNT_W'(CLKS_PER_BIT - 1);
	localparam logic [COUNT_W-1:0] HALF_BIT = COUNT_W'(CLKS_PER_BIT / 2 - 1);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_START = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_STOP = 2'd3;

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [1:0] state;
	logic [COUNT_W-1:0] count;
	logic [2:0] bit_index;
	uart_byte_t shift;

	// Two flop synchronizer plus one flop for edge detection.
	// The line idles high.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			count <= '0;
			bit_index <= '0;
			o_byte_valid <= 1'b0;
			o_frame_error <= 1'b0;
		end else begin
			o_byte_valid <= 1'b0;
			o_frame_error <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Falling edge marks a possible start bit.
					if (rx_prev && !rx_sync) begin
						state <= ST_START;
						count <= HALF_BIT;
					end
				end
				ST_START: begin
					if (count != '0) begin
						count <= count - 1'b1;
					end else if (rx_sync) begin
						// Only a glitch on the line.
						state <= ST_IDLE;
					end else begin
						state <= ST_DATA;
						count <= FULL_BIT;
						bit_index <= '0;
					end
				end
				ST_DATA: begin
					if (count != '0) begin
						count <= count - 1'b1;
					end else begin
						count <= FULL_BIT;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7) begin
							state <= ST_STOP;
						end
					end
				end
				ST_STOP: begin
					if (count != '0) begin
						count <= count - 1'b1;
					end else begin
						state <= ST_IDLE;
						o_byte_valid <= rx_sync;
						o_frame_error <= !rx_sync;
					end
				end
			endcase
		end
	end

	// LSB arrives first, so shift in from the top.
	always_ff @(posedge i_clock) begin
		if (state == ST_DATA && count == '0) begin
			shift <= {rx_sync, shift[7:1]};
		end
	end

	assign o_byte = shift;

	a_one_outcome: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_byte_valid && o_frame_error));

endmodule

// File: rtl/uart_rx_fifo.sv
`timescale 1ns/1ps

module uart_rx_fifo import uart_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_write,
	input uart_byte_t i_wdata,
	input logic i_read,
	output uart_byte_t o_rdata,
	output logic o_empty,
	output logic o_full,
	output logic o_overrun
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	uart_byte_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_write;
	logic do_read;

	assign o_empty = (count == '0);
	assign o_full = (count == (PTR_W + 1)'(FIFO_DEPTH));

	// A write into a full buffer is dropped.
	assign do_write = i_write && !o_full;
	assign do_read = i_read && !o_empty;

	// Show-ahead output.
	assign o_rdata = mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (do_write) begin
			mem[wr_ptr] <= i_wdata;
		end
	end

	// Pointers wrap naturally since the depth is a power of two.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_overrun <= 1'b0;
		end else begin
			o_overrun <= i_write && o_full;
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_empty_read: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_read && o_empty));

endmodule

// File: rtl/uart_rx_regs.sv
`timescale 1ns/1ps

module uart_rx_regs import uart_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input uart_addr_t i_address,
	input uart_byte_t i_fifo_rdata,
	input logic i_fifo_empty,
	input logic i_fifo_full,
	input logic i_frame_error,
	input logic i_overrun,
	output logic [31:0] o_rdata,
	output logic o_ready,
	output logic o_fifo_read
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WAIT = 2'd1;
	localparam logic [1:0] ST_ANSWER = 2'd2;
	localparam logic [1:0] ST_HOLD = 2'd3;

	logic [1:0] state;
	logic frame_error_sticky;
	logic overrun_sticky;
	logic status_read;
	uart_rdata_u word;

	assign status_read = (state == ST_ANSWER) && (i_address == addr_status);

	// Read word for the current address.
	always_comb begin
		word = '0;
		case (i_address)
			addr_data: word.data.value = i_fifo_rdata;
			addr_status: begin
				word.status.flags.overrun = overrun_sticky;
				word.status.flags.empty = i_fifo_empty;
				word.status.flags.frame_error = frame_error_sticky;
				word.status.flags.full = i_fifo_full;
			end
			// Reserved addresses read as zero.
			addr_reserved_2, addr_reserved_3: word = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_ready <= 1'b0;
			o_fifo_read <= 1'b0;
		end else begin
			o_fifo_read <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_request) begin
						// A data read waits for a byte.
						if (i_address == addr_data && i_fifo_empty) begin
							state <= ST_WAIT;
						end else begin
							state <= ST_ANSWER;
						end
					end
				end
				ST_WAIT: begin
					if (!i_request) begin
						state <= ST_IDLE;
					end else if (!i_fifo_empty) begin
						state <= ST_ANSWER;
					end
				end
				ST_ANSWER: begin
					state <= ST_HOLD;
					o_ready <= 1'b1;
					o_fifo_read <= (i_address == addr_data);
				end
				ST_HOLD: begin
					if (!i_request) begin
						state <= ST_IDLE;
						o_ready <= 1'b0;
					end
				end
			endcase
		end
	end

	// Loaded once per read and held stable.
	always_ff @(posedge i_clock) begin
		if (state == ST_ANSWER) begin
			o_rdata <= word;
		end
	end

	// New errors in the clearing cycle survive.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			frame_error_sticky <= 1'b0;
			overrun_sticky <= 1'b0;
		end else begin
			frame_error_sticky <= (frame_error_sticky && !status_read) || i_frame_error;
			overrun_sticky <= (overrun_sticky && !status_read) || i_overrun;
		end
	end

	// Ready only follows a request that was live the cycle before.
	a_ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |-> $past(i_request));

endmodule

// File: rtl/uart_rx_top.sv
`timescale 1ns/1ps

module uart_rx_top import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 16,
	parameter int FIFO_DEPTH = 4
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_rx,
	input logic i_request,
	input uart_addr_t i_address,
	output logic [31:0] o_rdata,
	output logic o_ready
);

	uart_byte_t rx_byte;
	logic rx_byte_valid;
	logic rx_frame_error;
	uart_byte_t fifo_rdata;
	logic fifo_empty;
	logic fifo_full;
	logic fifo_overrun;
	logic fifo_read;

	// Serial line in.
	uart_rx_sampler #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) sampler0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rx(i_rx),
		.o_byte(rx_byte),
		.o_byte_valid(rx_byte_valid),
		.o_frame_error(rx_frame_error)
	);

	uart_rx_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) fifo0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(rx_byte_valid),
		.i_wdata(rx_byte),
		.i_read(fifo_read),
		.o_rdata(fifo_rdata),
		.o_empty(fifo_empty),
		.o_full(fifo_full),
		.o_overrun(fifo_overrun)
	);

	// Host register port.
	uart_rx_regs regs0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_address(i_address),
		.i_fifo_rdata(fifo_rdata),
		.i_fifo_empty(fifo_empty),
		.i_fifo_full(fifo_full),
		.i_frame_error(rx_frame_error),
		.i_overrun(fifo_overrun),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_fifo_read(fifo_read)
	);

endmodule

// File: verification/uart_line_driver.svh
`ifndef UART_LINE_DRIVER_SVH
`define UART_LINE_DRIVER_SVH

// Holds the line at one level for one bit period.
task automatic drive_bit(input logic level);
	@(posedge clock);
	rx <= level;
	repeat (BIT_CLKS - 1) @(posedge clock);
endtask

// Start bit, data LSB first, stop bit, then one idle bit.
task automatic send_frame(input uart_byte_t byte_value, input logic bad_stop);
	drive_bit(1'b0);
	for (int i = 0; i < 8; i++) begin
		drive_bit(byte_value[i]);
	end
	drive_bit(!bad_stop);
	drive_bit(1'b1);
endtask

// One register read, optionally holding the request after ready.
task automatic bus_read(input uart_addr_t addr, input int hold_cycles);
	int waited;
	waited = 0;
	@(posedge clock);
	request <= 1'b1;
	address <= addr;
	@(posedge clock);
	while (!ready && waited < READ_TIMEOUT) begin
		@(posedge clock);
		waited++;
	end
	if (!ready) begin
		$display("Timeout: read at address %0d never got o_ready", addr);
		error_count++;
	end
	repeat (hold_cycles) @(posedge clock);
	request <= 1'b0;
	waited = 0;
	@(posedge clock);
	while (ready && waited < READ_TIMEOUT) begin
		@(posedge clock);
		waited++;
	end
	if (ready) begin
		$display("Timeout: o_ready stayed high after the request was dropped");
		error_count++;
	end
	// Idle cycle between reads.
	@(posedge clock);
endtask

`endif

// File: verification/uart_rx_tb.sv
`timescale 1ns/1ps

module uart_rx_tb import uart_pkg::*; ();

	localparam int BIT_CLKS = 16;
	localparam int FIFO_DEPTH = 4;
	localparam int READ_TIMEOUT = 400;

	logic clock;
	logic reset;
	logic rx;
	logic request;
	uart_addr_t address;
	logic [31:0] rdata;
	logic ready;

	integer seed;
	int error_count;
	int errors_before;
	int tests_passed;
	int tests_failed;
	logic check_armed;
	logic ready_forbidden;
	logic exp_overrun;
	logic exp_frame_error;
	uart_rdata_u expected_word;
	uart_byte_t expected_q[$];
	uart_byte_t value;

	uart_rx_top #(
		.CLKS_PER_BIT(BIT_CLKS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) dut0 (
		.i_clock(clock),
		.i_reset(reset),
		.i_rx(rx),
		.i_request(request),
		.i_address(address),
		.o_rdata(rdata),
		.o_ready(ready)
	);

	`include "uart_line_driver.svh"

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	a_ready_requested: assert property (@(posedge clock) disable iff (reset)
		$rose(ready) |-> check_armed)
		else begin
			$display("** Error: o_ready = %h with no read pending, expected 0", ready);
			error_count++;
		end

	// Covers both the answer word and its stability while held.
	a_rdata: assert property (@(posedge clock) disable iff (reset)
		ready && check_armed |-> rdata == expected_word)
		else begin
			$display("** Error: o_rdata = %h, expected %h", rdata, expected_word);
			error_count++;
		end

	a_ready_low: assert property (@(posedge clock) disable iff (reset)
		ready_forbidden |-> !ready)
		else begin
			$display("** Error: o_ready = %h, expected 0", ready);
			error_count++;
		end

	// Ready stays up while the request is held.
	a_ready_held: assert property (@(posedge clock) disable iff (reset)
		ready && request |=> ready)
		else begin
			$display("** Error: o_ready = %h with the request held, expected 1",
				$sampled(ready));
			error_count++;
		end

	// Ready falls one cycle after the request drops.
	a_ready_falls: assert property (@(posedge clock) disable iff (reset)
		ready && !request |=> !ready)
		else begin
			$display("** Error: o_ready = %h after the request dropped, expected 0",
				$sampled(ready));
			error_count++;
		end

	// Sticky and scoreboard model follows each frame.
	task automatic send_byte(input uart_byte_t b, input logic bad_stop);
		if (bad_stop) begin
			exp_frame_error = 1'b1;
		end else if (expected_q.size() == FIFO_DEPTH) begin
			exp_overrun = 1'b1;
		end else begin
			expected_q.push_back(b);
		end
		send_frame(b, bad_stop);
	endtask

	task automatic read_status();
		expected_word = '0;
		expected_word.status.flags.overrun = exp_overrun;
		expected_word.status.flags.empty = (expected_q.size() == 0);
		expected_word.status.flags.frame_error = exp_frame_error;
		expected_word.status.flags.full = (expected_q.size() == FIFO_DEPTH);
		check_armed = 1'b1;
		bus_read(addr_status, 0);
		check_armed = 1'b0;
		exp_overrun = 1'b0;
		exp_frame_error = 1'b0;
	endtask

	task automatic read_data(input int hold_cycles);
		expected_word = '0;
		expected_word.data.value = expected_q.pop_front();
		check_armed = 1'b1;
		bus_read(addr_data, hold_cycles);
		check_armed = 1'b0;
	endtask

	task automatic read_reserved(input uart_addr_t addr);
		expected_word = '0;
		check_armed = 1'b1;
		bus_read(addr, 0);
		check_armed = 1'b0;
	endtask

	task automatic end_test(input string name);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("Test %s: pass", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAIL with %0d errors", name, error_count - errors_before);
		end
		errors_before = error_count;
	endtask

	initial begin
		seed = 32'h5c6e07d9;
		reset = 1'b1;
		rx = 1'b1;
		request = 1'b0;
		address = addr_data;
		error_count = 0;
		errors_before = 0;
		tests_passed = 0;
		tests_failed = 0;
		check_armed = 1'b0;
		ready_forbidden = 1'b0;
		exp_overrun = 1'b0;
		exp_frame_error = 1'b0;
		expected_word = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		repeat (2) @(posedge clock);

		read_status();
		end_test("1 reset status");

		for (int n = 0; n < 8; n++) begin
			value = uart_byte_t'($random(seed));
			send_byte(value, 1'b0);
			read_data(0);
		end
		end_test("2 random bytes");

		// Fill up with a status read after each frame.
		for (int n = 0; n < FIFO_DEPTH; n++) begin
			send_byte(uart_byte_t'($random(seed)), 1'b0);
			read_status();
		end
		for (int n = 0; n < FIFO_DEPTH; n++) begin
			read_data(0);
		end
		end_test("3 fill and drain");

		for (int n = 0; n <= FIFO_DEPTH; n++) begin
			send_byte(uart_byte_t'($random(seed)), 1'b0);
		end
		read_status();
		read_status();
		for (int n = 0; n < FIFO_DEPTH; n++) begin
			read_data(0);
		end
		read_status();
		end_test("4 overrun");

		send_byte(uart_byte_t'($random(seed)), 1'b1);
		read_status();
		read_status();
		end_test("5 frame error");

		// Read waits on an empty FIFO until the frame lands.
		value = uart_byte_t'($random(seed));
		expected_q.push_back(value);
		ready_forbidden = 1'b1;
		fork
			read_data(8);
			begin
				repeat (60) @(posedge clock);
				ready_forbidden = 1'b0;
				send_frame(value, 1'b0);
			end
		join
		read_reserved(addr_reserved_2);
		read_reserved(addr_reserved_3);
		end_test("6 blocking read");

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: uart_rx_top.f
+incdir+verification
rtl/uart_pkg.sv
rtl/uart_rx_sampler.sv
rtl/uart_rx_fifo.sv
rtl/uart_rx_regs.sv
rtl/uart_rx_top.sv
verification/uart_rx_tb.sv
